// File: cpuTop.f
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/datapath.sv
rtl/wordMemory.sv
rtl/controlUnit.sv
rtl/cpuTop.sv
tests/cpuTop_assertions.sv
tests/cpuTop_tb.sv

// File: rtl/alu.sv
`timescale 1ns/1ps
module alu (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t aluOp,
	output cpuPkg::word_t result
);
	import cpuPkg::*;

	// a is Y, b is the bus
	always_comb begin
		case (aluOp)
			aluAdd: begin
				result = a + b;
			end
			aluSub: begin
				result = a - b;
			end
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			aluInc: begin
				result = b + word_t'(1); // PC step during fetch
			end
			default: begin
				result = b;
			end
		endcase
	end

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/1ps
module controlUnit (
	input logic clk,
	input logic reset,
	input logic start,
	input cpuPkg::word_t ir,
	input logic progValid,
	input logic outReady,
	output logic progReady,
	output logic progWe,
	output logic outValid,
	output logic halted,
	output cpuPkg::ctrlState_t state,
	output cpuPkg::busSel_t busSelect,
	output logic pcIn,
	output logic marIn,
	output logic mdrIn,
	output logic mdRead,
	output logic irIn,
	output logic yIn,
	output logic zIn,
	output logic rIn,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rOut,
	output logic baOut,
	output cpuPkg::aluOp_t aluOp,
	output logic memRead,
	output logic memWrite
);
	import cpuPkg::*;

	ctrlState_t nextState;
	opcode_t op;
	logic isAlu;
	logic isMem;

	assign op = ir[opMsb:opLsb];
	assign isAlu = (op == opAdd) || (op == opSub) || (op == opAnd) || (op == opOr);
	assign isMem = (op == opLd) || (op == opSt); // address is Rb + C

	assign progReady = (state == idle);
	assign progWe = progValid && progReady;
	assign outValid = (state == outWait);
	assign halted = (state == cpuPkg::halted);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: nextState = start ? t0 : idle;
			t0: nextState = t1;
			t1: nextState = t2;
			t2: nextState = t3;
			t3: begin
				if (op == opOut) begin
					nextState = outWait;
				end else if (op == opHalt) begin
					nextState = cpuPkg::halted;
				end else if (isAlu || isMem || op == opLdi) begin
					nextState = t4;
				end else begin
					nextState = t0; // unknown opcode is skipped
				end
			end
			t4: nextState = t5;
			t5: nextState = isMem ? t6 : t0;
			t6: nextState = t7;
			t7: nextState = (op == opLd) ? t8 : t0;
			t8: nextState = t0;
			outWait: nextState = outReady ? t0 : outWait;
			default: nextState = state;
		endcase
	end

	always_comb begin
		busSelect = '0;
		pcIn = 1'b0;
		marIn = 1'b0;
		mdrIn = 1'b0;
		mdRead = 1'b0;
		irIn = 1'b0;
		yIn = 1'b0;
		zIn = 1'b0;
		rIn = 1'b0;
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		rOut = 1'b0;
		baOut = 1'b0;
		aluOp = aluAdd;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (state)
			t0: begin
				busSelect[busPc] = 1'b1; // PC to MAR, PC+1 to Z
				marIn = 1'b1;
				aluOp = aluInc;
				zIn = 1'b1;
			end
			t1: begin
				busSelect[busZ] = 1'b1;
				pcIn = 1'b1;
				memRead = 1'b1;
			end
			t2: begin
				mdrIn = 1'b1;
				mdRead = 1'b1;
				irIn = 1'b1;
			end
			t3: begin
				busSelect[busReg] = 1'b1;
				if (op == opOut) begin
					gra = 1'b1; // Ra onto the bus for the out register
					rOut = 1'b1;
				end else if (isAlu) begin
					grb = 1'b1;
					rOut = 1'b1;
					yIn = 1'b1;
				end else begin
					grb = 1'b1;
					baOut = 1'b1;
					yIn = 1'b1;
				end
			end
			t4: begin
				zIn = 1'b1;
				if (isAlu) begin
					busSelect[busReg] = 1'b1;
					grc = 1'b1;
					rOut = 1'b1;
					case (op)
						opSub: aluOp = aluSub;
						opAnd: aluOp = aluAnd;
						opOr: aluOp = aluOr;
						default: aluOp = aluAdd;
					endcase
				end else begin
					busSelect[busConst] = 1'b1; // Y + C
				end
			end
			t5: begin
				busSelect[busZ] = 1'b1;
				if (isMem) begin
					marIn = 1'b1;
				end else begin
					gra = 1'b1;
					rIn = 1'b1;
				end
			end
			t6: begin
				if (op == opLd) begin
					memRead = 1'b1;
				end else begin
					busSelect[busReg] = 1'b1; // store data into MDR
					gra = 1'b1;
					rOut = 1'b1;
					mdrIn = 1'b1;
				end
			end
			t7: begin
				if (op == opLd) begin
					mdrIn = 1'b1;
					mdRead = 1'b1;
				end else begin
					memWrite = 1'b1;
				end
			end
			t8: begin
				busSelect[busMdr] = 1'b1;
				gra = 1'b1;
				rIn = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: rtl/cpuPkg.sv
package cpuPkg;

	localparam int wordWidth = 32;
	localparam int regCount = 16;
	localparam int regIdxWidth = 4;
	localparam int addrWidth = 9;
	localparam int memDepth = 512;
	localparam int opWidth = 5;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regIdxWidth-1:0] regIdx_t;
	typedef logic [addrWidth-1:0] addr_t;
	typedef logic [opWidth-1:0] opcode_t;

	// instruction field positions in IR
	localparam int opMsb = 31;
	localparam int opLsb = 27;
	localparam int raMsb = 26;
	localparam int raLsb = 23;
	localparam int rbMsb = 22;
	localparam int rbLsb = 19;
	localparam int rcMsb = 18;
	localparam int rcLsb = 15;
	localparam int cWidth = 19;
	localparam int cMsb = cWidth - 1; // sign bit of C

	localparam opcode_t opLd = 5'd0;
	localparam opcode_t opLdi = 5'd1;
	localparam opcode_t opSt = 5'd2;
	localparam opcode_t opAdd = 5'd3;
	localparam opcode_t opSub = 5'd4;
	localparam opcode_t opAnd = 5'd5;
	localparam opcode_t opOr = 5'd6;
	localparam opcode_t opOut = 5'd7;
	localparam opcode_t opHalt = 5'd8;

	// one-hot bus source positions
	localparam int busSrcCount = 5;
	localparam int busReg = 0;
	localparam int busPc = 1;
	localparam int busMdr = 2;
	localparam int busZ = 3;
	localparam int busConst = 4;

	typedef logic [busSrcCount-1:0] busSel_t;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluInc} aluOp_t;

	typedef enum logic [3:0] {
		idle, t0, t1, t2, t3, t4, t5, t6, t7, t8, outWait, halted
	} ctrlState_t;

endpackage

// File: rtl/cpuTop.sv
`timescale 1ns/1ps
module cpuTop (
	input logic clk,
	input logic reset,
	input logic start,
	input logic progValid,
	output logic progReady,
	input cpuPkg::addr_t progAddr,
	input cpuPkg::word_t progData,
	output logic outValid,
	input logic outReady,
	output cpuPkg::word_t outData,
	output logic halted
);
	import cpuPkg::*;

	ctrlState_t state;
	busSel_t busSelect;
	aluOp_t aluOp;
	logic progWe;
	logic pcIn, marIn, mdrIn, mdRead, irIn, yIn, zIn, rIn;
	logic gra, grb, grc, rOut, baOut;
	logic memRead, memWrite;
	word_t ir;
	word_t mdr;
	word_t busValue;
	word_t rdData;
	addr_t memAddr;

	controlUnit ctrl (
		.clk(clk), .reset(reset), .start(start), .ir(ir),
		.progValid(progValid), .outReady(outReady),
		.progReady(progReady), .progWe(progWe), .outValid(outValid),
		.halted(halted), .state(state), .busSelect(busSelect),
		.pcIn(pcIn), .marIn(marIn), .mdrIn(mdrIn), .mdRead(mdRead),
		.irIn(irIn), .yIn(yIn), .zIn(zIn), .rIn(rIn),
		.gra(gra), .grb(grb), .grc(grc), .rOut(rOut), .baOut(baOut),
		.aluOp(aluOp), .memRead(memRead), .memWrite(memWrite)
	);

	datapath dp (
		.clk(clk), .reset(reset), .busSelect(busSelect),
		.pcIn(pcIn), .marIn(marIn), .mdrIn(mdrIn), .mdRead(mdRead),
		.irIn(irIn), .yIn(yIn), .zIn(zIn),
		.gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut), .baOut(baOut),
		.aluOp(aluOp), .memData(rdData),
		.ir(ir), .memAddr(memAddr), .mdr(mdr), .busValue(busValue)
	);

	wordMemory mem (
		.clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.memRead(memRead), .memWrite(memWrite), .addr(memAddr),
		.wrData(mdr), .rdData(rdData)
	);

	// out puts Ra on the bus in t3, held here through outWait
	always_ff @(posedge clk) begin
		if (state == t3) begin
			outData <= busValue;
		end
	end

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ps
module datapath (
	input logic clk,
	input logic reset,
	input cpuPkg::busSel_t busSelect,
	input logic pcIn,
	input logic marIn,
	input logic mdrIn,
	input logic mdRead,
	input logic irIn,
	input logic yIn,
	input logic zIn,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	input cpuPkg::aluOp_t aluOp,
	input cpuPkg::word_t memData,
	output cpuPkg::word_t ir,
	output cpuPkg::addr_t memAddr,
	output cpuPkg::word_t mdr,
	output cpuPkg::word_t busValue
);
	import cpuPkg::*;

	word_t pc;
	word_t y;
	word_t z;
	word_t regOut;
	word_t aluResult;
	word_t constC;
	word_t mdrNext;

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.baOut(baOut),
		.rIn(rIn),
		.rOut(rOut),
		.ir(ir),
		.busIn(busValue),
		.regOut(regOut)
	);

	alu aluUnit (
		.a(y),
		.b(busValue),
		.aluOp(aluOp),
		.result(aluResult)
	);

	assign constC = {{(wordWidth - cWidth){ir[cMsb]}}, ir[cMsb:0]};

	// one-hot select, so an OR of the gated sources
	always_comb begin
		busValue = '0;
		if (busSelect[busReg]) begin
			busValue = busValue | regOut;
		end
		if (busSelect[busPc]) begin
			busValue = busValue | pc;
		end
		if (busSelect[busMdr]) begin
			busValue = busValue | mdr;
		end
		if (busSelect[busZ]) begin
			busValue = busValue | z;
		end
		if (busSelect[busConst]) begin
			busValue = busValue | constC;
		end
	end

	// memory data or the bus into MDR
	assign mdrNext = mdRead ? memData : busValue;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (pcIn) begin
				pc <= busValue;
			end
			if (irIn) begin
				ir <= mdrNext; // same word that MDR takes in t2
			end
		end
	end

	always_ff @(posedge clk) begin
		if (marIn) begin
			memAddr <= busValue[addrWidth-1:0];
		end
		if (mdrIn) begin
			mdr <= mdrNext;
		end
		if (yIn) begin
			y <= busValue;
		end
		if (zIn) begin
			z <= aluResult;
		end
	end

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps
module registerFile (
	input logic clk,
	input logic reset,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic baOut,
	input logic rIn,
	input logic rOut,
	input cpuPkg::word_t ir,
	input cpuPkg::word_t busIn,
	output cpuPkg::word_t regOut
);
	import cpuPkg::*;

	word_t regs [regCount];
	regIdx_t sel;

	// field select from the IR
	always_comb begin
		if (gra) begin
			sel = ir[raMsb:raLsb];
		end else if (grb) begin
			sel = ir[rbMsb:rbLsb];
		end else if (grc) begin
			sel = ir[rcMsb:rcLsb];
		end else begin
			sel = '0;
		end
	end

	always_comb begin
		if (baOut && sel == '0) begin
			regOut = '0; // R0 as base means no base
		end else if (rOut || baOut) begin
			regOut = regs[sel];
		end else begin
			regOut = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[sel] <= busIn;
		end
	end

endmodule

// File: rtl/wordMemory.sv
`timescale 1ns/1ps
module wordMemory (
	input logic clk,
	input logic progWe,
	input cpuPkg::addr_t progAddr,
	input cpuPkg::word_t progData,
	input logic memRead,
	input logic memWrite,
	input cpuPkg::addr_t addr,
	input cpuPkg::word_t wrData,
	output cpuPkg::word_t rdData
);
	import cpuPkg::*;

	word_t mem [memDepth];

	// host load only happens in idle, so the ports never collide
	always_ff @(posedge clk) begin
		if (progWe) begin
			mem[progAddr] <= progData;
		end else if (memWrite) begin
			mem[addr] <= wrData;
		end
	end

	always_ff @(posedge clk) begin
		if (memRead) begin
			rdData <= mem[addr]; // valid the cycle after memRead
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module cpuTop_tb \
	--Mdir "$buildDir" -o cpuTop_sim -f cpuTop.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$buildDir/cpuTop_sim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Test failed" "$logFile"; then
	echo "simulation reported a failure, see $logFile"
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

echo "simulation passed"
exit 0

// File: tests/cpuTop_assertions.sv
`timescale 1ns/1ps
module cpuTop_assertions (
	input logic clk,
	input logic reset,
	input logic progReady,
	input logic outValid,
	input logic outReady,
	input logic halted,
	input logic memRead,
	input logic memWrite
);

	outHeld: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid)
	else $error("out request withdrawn before outReady");

	// load port closes for good once running
	loadClosed: assert property (@(posedge clk) disable iff (reset)
		!progReady |=> !progReady)
	else $error("progReady rose again after the processor left idle");

	haltSticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
	else $error("halted dropped without reset");

	memExclusive: assert property (@(posedge clk) !(memRead && memWrite))
	else $error("memRead and memWrite high together");

endmodule

bind controlUnit cpuTop_assertions checks (
	.clk(clk), .reset(reset),
	.progReady(progReady), .outValid(outValid), .outReady(outReady),
	.halted(halted), .memRead(memRead), .memWrite(memWrite)
);

// File: tests/cpuTop_tb.sv
`timescale 1ns/1ps
module cpuTop_tb;
	import cpuPkg::*;

	localparam int randomCount = 40;
	localparam int runTimeout = 5000; // cycles until halt
	localparam int haltWatch = 20;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic progValid;
	logic progReady;
	addr_t progAddr;
	word_t progData;
	logic outValid;
	logic outReady;
	word_t outData;
	logic halted;

	word_t progWords [$];
	word_t expectedOuts [$];

	cpuTop uut (
		.clk(clk), .reset(reset), .start(start),
		.progValid(progValid), .progReady(progReady), .progAddr(progAddr),
		.progData(progData), .outValid(outValid), .outReady(outReady),
		.outData(outData), .halted(halted)
	);

	always #4 clk = ~clk;

	task automatic abortRun();
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkWord(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s got %h expected %h", name, actual, expected);
			abortRun();
		end
	endtask

	task automatic checkFlag(string name, logic actual, logic expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s got %h expected %h", name, actual, expected);
			abortRun();
		end
	endtask

	// op | Ra | Rb | low 19 bits (Rc or C)
	function automatic word_t encode(opcode_t op, regIdx_t ra, regIdx_t rb, logic [18:0] low);
		return {op, ra, rb, low};
	endfunction

	task automatic buildProgram();
		addr_t stored [$];
		addr_t a;
		int kind;
		regIdx_t ra, rb, rc;
		for (int i = 0; i < randomCount; i++) begin
			kind = $urandom % 8;
			ra = regIdx_t'($urandom % 16);
			rb = regIdx_t'($urandom % 16);
			rc = regIdx_t'($urandom % 16);
			if (kind == 1 && stored.size() == 0) begin
				kind = 2; // nothing stored yet to load back
			end
			case (kind)
				0: begin
					if ($urandom % 3 == 0) begin
						rb = '0;
					end
					progWords.push_back(encode(opLdi, ra, rb, 19'($urandom)));
				end
				1: begin
					a = stored[$urandom % stored.size()];
					ra = regIdx_t'(1 + $urandom % 15);
					progWords.push_back(encode(opLd, ra, 4'd0, {10'd0, a}));
				end
				2: begin
					a = addr_t'(256 + $urandom % 256); // data region above the program
					stored.push_back(a);
					progWords.push_back(encode(opSt, ra, 4'd0, {10'd0, a}));
				end
				3: progWords.push_back(encode(opAdd, ra, rb, {rc, 15'd0}));
				4: progWords.push_back(encode(opSub, ra, rb, {rc, 15'd0}));
				5: progWords.push_back(encode(opAnd, ra, rb, {rc, 15'd0}));
				6: progWords.push_back(encode(opOr, ra, rb, {rc, 15'd0}));
				default: progWords.push_back(encode(opOut, ra, 4'd0, 19'd0));
			endcase
		end
		for (int r = 1; r < 16; r++) begin
			progWords.push_back(encode(opOut, regIdx_t'(r), 4'd0, 19'd0));
		end
		progWords.push_back(encode(opHalt, 4'd0, 4'd0, 19'd0));
	endtask

	// ISA reference, straight-line so a single pass suffices
	task automatic runModel();
		word_t regs [16];
		word_t dataMem [addr_t];
		word_t w;
		word_t base;
		word_t c;
		opcode_t op;
		regIdx_t ra, rb, rc;
		for (int r = 0; r < 16; r++) begin
			regs[r] = '0;
		end
		foreach (progWords[i]) begin
			w = progWords[i];
			op = w[31:27];
			ra = w[26:23];
			rb = w[22:19];
			rc = w[18:15];
			c = {{13{w[18]}}, w[18:0]};
			base = (rb == 4'd0) ? '0 : regs[rb]; // R0 as base is zero
			case (op)
				opLdi: regs[ra] = base + c;
				opLd: regs[ra] = dataMem[addr_t'(base + c)];
				opSt: dataMem[addr_t'(base + c)] = regs[ra];
				opAdd: regs[ra] = regs[rb] + regs[rc];
				opSub: regs[ra] = regs[rb] - regs[rc];
				opAnd: regs[ra] = regs[rb] & regs[rc];
				opOr: regs[ra] = regs[rb] | regs[rc];
				opOut: expectedOuts.push_back(regs[ra]);
				default: begin
				end
			endcase
		end
	endtask

	task automatic loadProgram();
		int gap;
		for (int i = 0; i < progWords.size(); i++) begin
			gap = $urandom % 3;
			repeat (gap) begin
				@(posedge clk);
				progValid <= 1'b0;
			end
			@(posedge clk);
			progValid <= 1'b1;
			progAddr <= addr_t'(i);
			progData <= progWords[i];
			@(negedge clk);
			checkFlag("progReady", progReady, 1'b1); // word taken on the next edge
		end
		@(posedge clk);
		progValid <= 1'b0;
	endtask

	task automatic collectOutputs();
		int cycles;
		logic pending;
		cycles = 0;
		pending = 1'b0;
		while (!halted && cycles < runTimeout) begin
			@(posedge clk);
			outReady <= ($urandom % 3) != 0;
			@(negedge clk);
			cycles++;
			if (pending) begin
				checkFlag("outValid", outValid, 1'b1);
			end
			if (outValid) begin
				if (expectedOuts.size() == 0) begin
					$display("an out word arrived after all expected words were taken");
					abortRun();
				end else begin
					checkWord("outData", outData, expectedOuts[0]);
					if (outReady) begin
						void'(expectedOuts.pop_front());
					end
				end
			end
			pending = outValid && !outReady; // must hold until accepted
		end
		if (!halted) begin
			$display("timeout after %0d cycles waiting for the processor to halt", cycles);
			abortRun();
		end
	endtask

	task automatic watchHalted();
		for (int i = 0; i < haltWatch; i++) begin
			@(posedge clk);
			outReady <= ($urandom % 2) != 0;
			@(negedge clk);
			checkFlag("halted", halted, 1'b1);
			checkFlag("outValid", outValid, 1'b0);
		end
	endtask

	initial begin
		void'($urandom(32'h35fc55f2));
		reset = 1'b1;
		start = 1'b0;
		progValid = 1'b0;
		progAddr = '0;
		progData = '0;
		outReady = 1'b0;
		buildProgram();
		runModel();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkFlag("progReady", progReady, 1'b1);
		checkFlag("outValid", outValid, 1'b0);
		checkFlag("halted", halted, 1'b0);
		loadProgram();
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		collectOutputs();
		watchHalted();
		if (expectedOuts.size() != 0) begin
			$display("processor halted with %0d out words never sent", expectedOuts.size());
			abortRun();
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule
